/* rv32v_pkg.sv */
`default_nettype none

package rv32v_pkg;

    // lane and register counts
    localparam int num_lanes = 4;
    localparam int num_vregs = 8;

    // one 32-bit element per lane
    typedef logic [31:0] word_t;

    // full vector register, lane k in bits 32k+31:32k
    typedef logic [num_lanes*32-1:0] vreg_t;

    typedef logic [2:0] vreg_addr_t;

    typedef logic [num_lanes-1:0] lane_mask_t;

    typedef logic [4:0] imm_t;

    // integer ALU operations
    typedef enum logic [3:0] {
        VALU_ADD = 4'd0,
        VALU_SUB = 4'd1,
        VALU_AND = 4'd2,
        VALU_OR  = 4'd3,
        VALU_XOR = 4'd4,
        VALU_SLL = 4'd5,
        VALU_SRL = 4'd6,
        VALU_SRA = 4'd7,
        VALU_SEQ = 4'd8,
        VALU_SLT = 4'd9,
        VALU_MIN = 4'd10,
        VALU_MAX = 4'd11,
        VALU_MV  = 4'd12,
        VALU_VID = 4'd13
    } valu_op_t;

    // where operand b comes from
    typedef enum logic [1:0] {
        SRC_VREG   = 2'd0,
        SRC_IMM    = 2'd1,
        SRC_SCALAR = 2'd2
    } vsrc_t;

endpackage

`default_nettype wire

/* rv32v_vector_bank.sv */
`default_nettype none

module rv32v_vector_bank (
    input  logic                   CLK,
    input  logic                   rst_n,
    input  rv32v_pkg::vreg_addr_t  rs1,
    input  rv32v_pkg::vreg_addr_t  rs2,
    input  rv32v_pkg::vreg_addr_t  rs3,
    input  rv32v_pkg::vreg_addr_t  wa,
    input  logic                   wen,
    input  rv32v_pkg::word_t       wdata,
    output rv32v_pkg::word_t       rdat1,
    output rv32v_pkg::word_t       rdat2,
    output rv32v_pkg::word_t       rdat3,
    output rv32v_pkg::word_t       v0
);

    rv32v_pkg::word_t regs [rv32v_pkg::num_vregs];

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            for (int i = 0; i < rv32v_pkg::num_vregs; i++) begin
                regs[i] <= '0;
            end
        end else if (wen) begin
            regs[wa] <= wdata;
        end
    end

    // combinational reads
    assign rdat1 = regs[rs1];
    assign rdat2 = regs[rs2];
    assign rdat3 = regs[rs3];

    // mask source tap
    assign v0 = regs[0];

endmodule

`default_nettype wire

/* rv32v_operand_stage.sv */
`default_nettype none

module rv32v_operand_stage (
    input  logic                   CLK,
    input  logic                   rst_n,
    input  logic                   uop_valid,
    output logic                   uop_ready,
    input  rv32v_pkg::valu_op_t    uop_op,
    input  rv32v_pkg::vsrc_t       uop_src,
    input  rv32v_pkg::vreg_addr_t  uop_vs1,
    input  rv32v_pkg::vreg_addr_t  uop_vs2,
    input  rv32v_pkg::vreg_addr_t  uop_vd,
    input  rv32v_pkg::imm_t        uop_imm,
    input  rv32v_pkg::word_t       uop_scalar,
    input  logic                   uop_mask_en,
    output logic                   pkt_valid,
    input  logic                   pkt_ready,
    output rv32v_pkg::valu_op_t    pkt_op,
    output rv32v_pkg::vreg_t       pkt_opa,
    output rv32v_pkg::vreg_t       pkt_opb,
    output rv32v_pkg::vreg_t       pkt_vd_old,
    output rv32v_pkg::lane_mask_t  pkt_mask,
    output rv32v_pkg::vreg_addr_t  pkt_vd,
    input  logic                   wb_en,
    input  rv32v_pkg::vreg_addr_t  wb_vd,
    input  rv32v_pkg::vreg_t       wb_data
);

    logic [rv32v_pkg::num_vregs-1:0] pending;
    logic [rv32v_pkg::num_vregs-1:0] wb_clr;
    logic [rv32v_pkg::num_vregs-1:0] acc_set;
    rv32v_pkg::vreg_t                rd1;
    rv32v_pkg::vreg_t                rd2;
    rv32v_pkg::vreg_t                rd3;
    rv32v_pkg::vreg_t                v0_all;
    rv32v_pkg::vreg_t                opb;
    rv32v_pkg::lane_mask_t           lane_mask;
    rv32v_pkg::word_t                imm_ext;
    logic                            hazard;
    logic                            out_stall;
    logic                            accept;

    for (genvar k = 0; k < rv32v_pkg::num_lanes; k++) begin : g_bank
        rv32v_vector_bank bank_inst (
            .CLK   (CLK),
            .rst_n (rst_n),
            .rs1   (uop_vs1),
            .rs2   (uop_vs2),
            .rs3   (uop_vd),
            .wa    (wb_vd),
            .wen   (wb_en),
            .wdata (wb_data[32*k +: 32]),
            .rdat1 (rd1[32*k +: 32]),
            .rdat2 (rd2[32*k +: 32]),
            .rdat3 (rd3[32*k +: 32]),
            .v0    (v0_all[32*k +: 32])
        );

        // bit 0 of v0 per lane enables the lane
        assign lane_mask[k] = uop_mask_en ? v0_all[32*k] : 1'b1;
    end

    // hold back on any read or write of a register still awaiting writeback
    assign hazard = pending[uop_vs2]
                  | (pending[uop_vs1] & (uop_src == rv32v_pkg::SRC_VREG))
                  | pending[uop_vd]
                  | (pending[0] & uop_mask_en);

    assign out_stall = pkt_valid & ~pkt_ready;
    assign uop_ready = ~out_stall & ~hazard;
    assign accept    = uop_valid & uop_ready;

    assign imm_ext = {{27{uop_imm[4]}}, uop_imm};

    always_comb begin
        case (uop_src)
            rv32v_pkg::SRC_IMM:    opb = {rv32v_pkg::num_lanes{imm_ext}};
            rv32v_pkg::SRC_SCALAR: opb = {rv32v_pkg::num_lanes{uop_scalar}};
            default:               opb = rd1;
        endcase
    end

    always_comb begin
        wb_clr  = '0;
        acc_set = '0;
        if (wb_en) begin
            wb_clr[wb_vd] = 1'b1;
        end
        if (accept) begin
            acc_set[uop_vd] = 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            pending <= '0;
        end else begin
            pending <= (pending & ~wb_clr) | acc_set;
        end
    end

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            pkt_valid <= 1'b0;
        end else if (accept) begin
            pkt_valid <= 1'b1;
        end else if (pkt_ready) begin
            pkt_valid <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            pkt_op     <= uop_op;
            pkt_opa    <= rd2;
            pkt_opb    <= opb;
            pkt_vd_old <= rd3;
            pkt_mask   <= lane_mask;
            pkt_vd     <= uop_vd;
        end
    end

endmodule

`default_nettype wire

/* rv32v_uop_fifo.sv */
`default_nettype none

module rv32v_uop_fifo #(
    parameter int DEPTH = 2
) (
    input  logic                   CLK,
    input  logic                   rst_n,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  rv32v_pkg::valu_op_t    in_op,
    input  rv32v_pkg::vreg_t       in_opa,
    input  rv32v_pkg::vreg_t       in_opb,
    input  rv32v_pkg::vreg_t       in_vd_old,
    input  rv32v_pkg::lane_mask_t  in_mask,
    input  rv32v_pkg::vreg_addr_t  in_vd,
    output logic                   out_valid,
    input  logic                   out_ready,
    output rv32v_pkg::valu_op_t    out_op,
    output rv32v_pkg::vreg_t       out_opa,
    output rv32v_pkg::vreg_t       out_opb,
    output rv32v_pkg::vreg_t       out_vd_old,
    output rv32v_pkg::lane_mask_t  out_mask,
    output rv32v_pkg::vreg_addr_t  out_vd
);

    rv32v_pkg::valu_op_t   op_mem     [DEPTH];
    rv32v_pkg::vreg_t      opa_mem    [DEPTH];
    rv32v_pkg::vreg_t      opb_mem    [DEPTH];
    rv32v_pkg::vreg_t      vd_old_mem [DEPTH];
    rv32v_pkg::lane_mask_t mask_mem   [DEPTH];
    rv32v_pkg::vreg_addr_t vd_mem     [DEPTH];

    logic [$clog2(DEPTH)-1:0]   wr_ptr;
    logic [$clog2(DEPTH)-1:0]   rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;
    logic                       push;
    logic                       pop;

    assign in_ready  = (count != ($clog2(DEPTH+1))'(DEPTH));
    assign out_valid = (count != '0);
    assign push      = in_valid & in_ready;
    assign pop       = out_valid & out_ready;

    // pointers wrap on their own since DEPTH is a power of two
    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (push) begin
            op_mem[wr_ptr]     <= in_op;
            opa_mem[wr_ptr]    <= in_opa;
            opb_mem[wr_ptr]    <= in_opb;
            vd_old_mem[wr_ptr] <= in_vd_old;
            mask_mem[wr_ptr]   <= in_mask;
            vd_mem[wr_ptr]     <= in_vd;
        end
    end

    // head entry straight from storage
    assign out_op     = op_mem[rd_ptr];
    assign out_opa    = opa_mem[rd_ptr];
    assign out_opb    = opb_mem[rd_ptr];
    assign out_vd_old = vd_old_mem[rd_ptr];
    assign out_mask   = mask_mem[rd_ptr];
    assign out_vd     = vd_mem[rd_ptr];

endmodule

`default_nettype wire

/* rv32v_lane_alu.sv */
`default_nettype none

module rv32v_lane_alu (
    input  rv32v_pkg::valu_op_t  op,
    input  logic [1:0]           lane_idx,
    input  rv32v_pkg::word_t     opa,
    input  rv32v_pkg::word_t     opb,
    input  rv32v_pkg::word_t     vd_old,
    input  logic                 mask_bit,
    output rv32v_pkg::word_t     res
);

    rv32v_pkg::word_t alu_res;
    logic [4:0]       shamt;
    logic             lt_signed;

    assign shamt     = opb[4:0];
    assign lt_signed = $signed(opa) < $signed(opb);

    always_comb begin
        case (op)
            rv32v_pkg::VALU_ADD: alu_res = opa + opb;
            rv32v_pkg::VALU_SUB: alu_res = opa - opb;
            rv32v_pkg::VALU_AND: alu_res = opa & opb;
            rv32v_pkg::VALU_OR:  alu_res = opa | opb;
            rv32v_pkg::VALU_XOR: alu_res = opa ^ opb;
            rv32v_pkg::VALU_SLL: alu_res = opa << shamt;
            rv32v_pkg::VALU_SRL: alu_res = opa >> shamt;
            rv32v_pkg::VALU_SRA: alu_res = $signed(opa) >>> shamt;
            // compares give 1 or 0 per lane, no mask packing
            rv32v_pkg::VALU_SEQ: alu_res = {31'b0, opa == opb};
            rv32v_pkg::VALU_SLT: alu_res = {31'b0, lt_signed};
            rv32v_pkg::VALU_MIN: alu_res = lt_signed ? opa : opb;
            rv32v_pkg::VALU_MAX: alu_res = lt_signed ? opb : opa;
            rv32v_pkg::VALU_MV:  alu_res = opb;
            rv32v_pkg::VALU_VID: alu_res = {30'b0, lane_idx};
            default:             alu_res = '0;
        endcase
    end

    // inactive lane keeps the old destination
    assign res = mask_bit ? alu_res : vd_old;

endmodule

`default_nettype wire

/* rv32v_ex_stage.sv */
`default_nettype none

module rv32v_ex_stage (
    input  logic                   CLK,
    input  logic                   rst_n,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  rv32v_pkg::valu_op_t    in_op,
    input  rv32v_pkg::vreg_t       in_opa,
    input  rv32v_pkg::vreg_t       in_opb,
    input  rv32v_pkg::vreg_t       in_vd_old,
    input  rv32v_pkg::lane_mask_t  in_mask,
    input  rv32v_pkg::vreg_addr_t  in_vd,
    output logic                   res_valid,
    input  logic                   res_ready,
    output rv32v_pkg::vreg_addr_t  res_vd,
    output rv32v_pkg::vreg_t       res_data,
    output logic                   wb_en,
    output rv32v_pkg::vreg_addr_t  wb_vd,
    output rv32v_pkg::vreg_t       wb_data
);

    rv32v_pkg::vreg_t lane_res;
    logic             load;

    for (genvar k = 0; k < rv32v_pkg::num_lanes; k++) begin : g_lane
        rv32v_lane_alu lane_alu_inst (
            .op       (in_op),
            .lane_idx (2'(k)),
            .opa      (in_opa[32*k +: 32]),
            .opb      (in_opb[32*k +: 32]),
            .vd_old   (in_vd_old[32*k +: 32]),
            .mask_bit (in_mask[k]),
            .res      (lane_res[32*k +: 32])
        );
    end

    // result register takes a new entry when empty or draining
    assign in_ready = ~res_valid | res_ready;
    assign load     = in_valid & in_ready;

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else if (in_ready) begin
            res_valid <= in_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (load) begin
            res_vd   <= in_vd;
            res_data <= lane_res;
        end
    end

    // writeback fires with the result transfer
    assign wb_en   = res_valid & res_ready;
    assign wb_vd   = res_vd;
    assign wb_data = res_data;

endmodule

`default_nettype wire

/* rv32v_ex_top.sv */
`default_nettype none

module rv32v_ex_top (
    input  logic                   CLK,
    input  logic                   rst_n,
    input  logic                   uop_valid,
    output logic                   uop_ready,
    input  rv32v_pkg::valu_op_t    uop_op,
    input  rv32v_pkg::vsrc_t       uop_src,
    input  rv32v_pkg::vreg_addr_t  uop_vs1,
    input  rv32v_pkg::vreg_addr_t  uop_vs2,
    input  rv32v_pkg::vreg_addr_t  uop_vd,
    input  rv32v_pkg::imm_t        uop_imm,
    input  rv32v_pkg::word_t       uop_scalar,
    input  logic                   uop_mask_en,
    output logic                   res_valid,
    input  logic                   res_ready,
    output rv32v_pkg::vreg_addr_t  res_vd,
    output rv32v_pkg::vreg_t       res_data
);

    // read stage to FIFO
    logic                  pkt_valid;
    logic                  pkt_ready;
    rv32v_pkg::valu_op_t   pkt_op;
    rv32v_pkg::vreg_t      pkt_opa;
    rv32v_pkg::vreg_t      pkt_opb;
    rv32v_pkg::vreg_t      pkt_vd_old;
    rv32v_pkg::lane_mask_t pkt_mask;
    rv32v_pkg::vreg_addr_t pkt_vd;

    // FIFO to execute
    logic                  ex_valid;
    logic                  ex_ready;
    rv32v_pkg::valu_op_t   ex_op;
    rv32v_pkg::vreg_t      ex_opa;
    rv32v_pkg::vreg_t      ex_opb;
    rv32v_pkg::vreg_t      ex_vd_old;
    rv32v_pkg::lane_mask_t ex_mask;
    rv32v_pkg::vreg_addr_t ex_vd;

    // writeback loop
    logic                  wb_en;
    rv32v_pkg::vreg_addr_t wb_vd;
    rv32v_pkg::vreg_t      wb_data;

    rv32v_operand_stage operand_stage_inst (
        .CLK         (CLK),
        .rst_n       (rst_n),
        .uop_valid   (uop_valid),
        .uop_ready   (uop_ready),
        .uop_op      (uop_op),
        .uop_src     (uop_src),
        .uop_vs1     (uop_vs1),
        .uop_vs2     (uop_vs2),
        .uop_vd      (uop_vd),
        .uop_imm     (uop_imm),
        .uop_scalar  (uop_scalar),
        .uop_mask_en (uop_mask_en),
        .pkt_valid   (pkt_valid),
        .pkt_ready   (pkt_ready),
        .pkt_op      (pkt_op),
        .pkt_opa     (pkt_opa),
        .pkt_opb     (pkt_opb),
        .pkt_vd_old  (pkt_vd_old),
        .pkt_mask    (pkt_mask),
        .pkt_vd      (pkt_vd),
        .wb_en       (wb_en),
        .wb_vd       (wb_vd),
        .wb_data     (wb_data)
    );

    rv32v_uop_fifo #(
        .DEPTH (2)
    ) uop_fifo_inst (
        .CLK        (CLK),
        .rst_n      (rst_n),
        .in_valid   (pkt_valid),
        .in_ready   (pkt_ready),
        .in_op      (pkt_op),
        .in_opa     (pkt_opa),
        .in_opb     (pkt_opb),
        .in_vd_old  (pkt_vd_old),
        .in_mask    (pkt_mask),
        .in_vd      (pkt_vd),
        .out_valid  (ex_valid),
        .out_ready  (ex_ready),
        .out_op     (ex_op),
        .out_opa    (ex_opa),
        .out_opb    (ex_opb),
        .out_vd_old (ex_vd_old),
        .out_mask   (ex_mask),
        .out_vd     (ex_vd)
    );

    rv32v_ex_stage ex_stage_inst (
        .CLK       (CLK),
        .rst_n     (rst_n),
        .in_valid  (ex_valid),
        .in_ready  (ex_ready),
        .in_op     (ex_op),
        .in_opa    (ex_opa),
        .in_opb    (ex_opb),
        .in_vd_old (ex_vd_old),
        .in_mask   (ex_mask),
        .in_vd     (ex_vd),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res_vd    (res_vd),
        .res_data  (res_data),
        .wb_en     (wb_en),
        .wb_vd     (wb_vd),
        .wb_data   (wb_data)
    );

endmodule

`default_nettype wire

/* tb_rv32v_ex_top.sv */
`default_nettype none

module tb_rv32v_ex_top;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int reset_cycles   = 10;
    // fill 8, random 300, masked 4 x 13, chains 4 x 10, back-pressure 80
    localparam int num_uops       = 480;
    localparam int timeout_cycles = 20 * num_uops + reset_cycles;

    logic                  CLK;
    logic                  rst_n;
    logic                  uop_valid;
    logic                  uop_ready;
    rv32v_pkg::valu_op_t   uop_op;
    rv32v_pkg::vsrc_t      uop_src;
    rv32v_pkg::vreg_addr_t uop_vs1;
    rv32v_pkg::vreg_addr_t uop_vs2;
    rv32v_pkg::vreg_addr_t uop_vd;
    rv32v_pkg::imm_t       uop_imm;
    rv32v_pkg::word_t      uop_scalar;
    logic                  uop_mask_en;
    logic                  res_valid;
    logic                  res_ready;
    rv32v_pkg::vreg_addr_t res_vd;
    rv32v_pkg::vreg_t      res_data;

    rv32v_pkg::vreg_t      model_regs [rv32v_pkg::num_vregs];
    rv32v_pkg::vreg_addr_t exp_vd_q   [$];
    rv32v_pkg::vreg_t      exp_data_q [$];
    string                 exp_name_q [$];
    int                    cycle_count = 0;
    logic                  bp_on;

    rv32v_ex_top rv32v_ex_top_inst (
        .CLK         (CLK),
        .rst_n       (rst_n),
        .uop_valid   (uop_valid),
        .uop_ready   (uop_ready),
        .uop_op      (uop_op),
        .uop_src     (uop_src),
        .uop_vs1     (uop_vs1),
        .uop_vs2     (uop_vs2),
        .uop_vd      (uop_vd),
        .uop_imm     (uop_imm),
        .uop_scalar  (uop_scalar),
        .uop_mask_en (uop_mask_en),
        .res_valid   (res_valid),
        .res_ready   (res_ready),
        .res_vd      (res_vd),
        .res_data    (res_data)
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    // expected value of one lane
    function automatic rv32v_pkg::word_t lane_ref(
        input rv32v_pkg::valu_op_t op,
        input int                  lane,
        input rv32v_pkg::word_t    a,
        input rv32v_pkg::word_t    b,
        input rv32v_pkg::word_t    old,
        input logic                active
    );
        int signed        sa;
        int signed        sb;
        rv32v_pkg::word_t r;
        sa = a;
        sb = b;
        if (!active) begin
            return old;
        end
        case (op)
            rv32v_pkg::VALU_ADD: r = a + b;
            rv32v_pkg::VALU_SUB: r = a - b;
            rv32v_pkg::VALU_AND: r = a & b;
            rv32v_pkg::VALU_OR:  r = a | b;
            rv32v_pkg::VALU_XOR: r = a ^ b;
            rv32v_pkg::VALU_SLL: r = a << b[4:0];
            rv32v_pkg::VALU_SRL: r = a >> b[4:0];
            rv32v_pkg::VALU_SRA: r = sa >>> b[4:0];
            rv32v_pkg::VALU_SEQ: r = (a == b) ? 32'd1 : 32'd0;
            rv32v_pkg::VALU_SLT: r = (sa < sb) ? 32'd1 : 32'd0;
            rv32v_pkg::VALU_MIN: r = (sa < sb) ? a : b;
            rv32v_pkg::VALU_MAX: r = (sa > sb) ? a : b;
            rv32v_pkg::VALU_MV:  r = b;
            rv32v_pkg::VALU_VID: r = rv32v_pkg::word_t'(lane);
            default:             r = '0;
        endcase
        return r;
    endfunction

    task automatic check_value(
        input string            name,
        input rv32v_pkg::vreg_t expected,
        input rv32v_pkg::vreg_t actual
    );
        if (actual !== expected) begin
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            $display("Checks failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    function automatic rv32v_pkg::vreg_addr_t rand_reg();
        return rv32v_pkg::vreg_addr_t'($urandom_range(rv32v_pkg::num_vregs - 1));
    endfunction

    function automatic rv32v_pkg::valu_op_t rand_op();
        return rv32v_pkg::valu_op_t'($urandom_range(13));
    endfunction

    function automatic rv32v_pkg::vsrc_t rand_src();
        return rv32v_pkg::vsrc_t'($urandom_range(2));
    endfunction

    // drive one micro-op, wait for the accept edge, then update the model
    task automatic issue_uop(
        input string                 name,
        input rv32v_pkg::valu_op_t   op,
        input rv32v_pkg::vsrc_t      src,
        input rv32v_pkg::vreg_addr_t vs1,
        input rv32v_pkg::vreg_addr_t vs2,
        input rv32v_pkg::vreg_addr_t vd,
        input rv32v_pkg::imm_t       imm,
        input rv32v_pkg::word_t      scalar,
        input logic                  mask_en
    );
        rv32v_pkg::vreg_t expected;
        rv32v_pkg::word_t opb;
        logic             active;
        uop_valid   <= 1'b1;
        uop_op      <= op;
        uop_src     <= src;
        uop_vs1     <= vs1;
        uop_vs2     <= vs2;
        uop_vd      <= vd;
        uop_imm     <= imm;
        uop_scalar  <= scalar;
        uop_mask_en <= mask_en;
        @(posedge CLK);
        while (!uop_ready) begin
            @(posedge CLK);
        end
        for (int k = 0; k < rv32v_pkg::num_lanes; k++) begin
            case (src)
                rv32v_pkg::SRC_IMM:    opb = {{27{imm[4]}}, imm};
                rv32v_pkg::SRC_SCALAR: opb = scalar;
                default:               opb = model_regs[vs1][32*k +: 32];
            endcase
            active = mask_en ? model_regs[0][32*k] : 1'b1;
            expected[32*k +: 32] = lane_ref(op, k, model_regs[vs2][32*k +: 32], opb,
                                            model_regs[vd][32*k +: 32], active);
        end
        model_regs[vd] = expected;
        exp_vd_q.push_back(vd);
        exp_data_q.push_back(expected);
        exp_name_q.push_back(name);
    endtask

    task automatic issue_random(input string name, input logic mask_en);
        issue_uop(name, rand_op(), rand_src(), rand_reg(), rand_reg(), rand_reg(),
                  rv32v_pkg::imm_t'($urandom), $urandom, mask_en);
    endtask

    task automatic fill_regs();
        issue_uop("fill_vid", rv32v_pkg::VALU_VID, rv32v_pkg::SRC_VREG, 3'd0, 3'd0, 3'd0,
                  '0, '0, 1'b0);
        for (int r = 1; r < 4; r++) begin
            issue_uop("fill_imm", rv32v_pkg::VALU_MV, rv32v_pkg::SRC_IMM, 3'd0, 3'd0,
                      rv32v_pkg::vreg_addr_t'(r), rv32v_pkg::imm_t'($urandom), '0, 1'b0);
        end
        for (int r = 4; r < rv32v_pkg::num_vregs; r++) begin
            issue_uop("fill_scalar", rv32v_pkg::VALU_MV, rv32v_pkg::SRC_SCALAR, 3'd0, 3'd0,
                      rv32v_pkg::vreg_addr_t'(r), '0, $urandom, 1'b0);
        end
    endtask

    task automatic masked_ops();
        for (int round = 0; round < 4; round++) begin
            // v0 lane k bit 0 ends up as bit k of a random scalar
            issue_uop("mask_load", rv32v_pkg::VALU_MV, rv32v_pkg::SRC_SCALAR, 3'd0, 3'd0,
                      3'd1, '0, $urandom, 1'b0);
            issue_uop("mask_load", rv32v_pkg::VALU_VID, rv32v_pkg::SRC_VREG, 3'd0, 3'd0,
                      3'd2, '0, '0, 1'b0);
            issue_uop("mask_load", rv32v_pkg::VALU_SRL, rv32v_pkg::SRC_VREG, 3'd2, 3'd1,
                      3'd0, '0, '0, 1'b0);
            repeat (10) issue_random("masked", 1'b1);
        end
    endtask

    task automatic dependency_chains();
        rv32v_pkg::vreg_addr_t prev;
        rv32v_pkg::vreg_addr_t next;
        for (int c = 0; c < 4; c++) begin
            prev = rand_reg();
            for (int i = 0; i < 10; i++) begin
                next = rand_reg();
                issue_uop("chain", rand_op(), rv32v_pkg::SRC_VREG, prev, prev, next,
                          '0, '0, 1'b0);
                prev = next;
            end
        end
    endtask

    task automatic backpressure_ops();
        for (int i = 0; i < 80; i++) begin
            // occasional bubble on the input side
            if ($urandom_range(3) == 0) begin
                uop_valid <= 1'b0;
                @(posedge CLK);
            end
            issue_random("backpressure", logic'($urandom_range(1)));
        end
    endtask

    // result port ready, low about 40 percent of cycles when enabled
    always @(posedge CLK) begin
        res_ready <= bp_on ? ($urandom_range(99) >= 40) : 1'b1;
    end

    always @(posedge CLK) begin : result_monitor
        string                 name;
        rv32v_pkg::vreg_addr_t vd_exp;
        rv32v_pkg::vreg_t      data_exp;
        if (rst_n && res_valid && res_ready) begin
            if (exp_vd_q.size() == 0) begin
                $display("result for v%0d arrived with no micro-op outstanding", res_vd);
                $display("Checks failed");
                $fatal(1, "unexpected result");
            end else begin
                name     = exp_name_q.pop_front();
                vd_exp   = exp_vd_q.pop_front();
                data_exp = exp_data_q.pop_front();
                check_value({name, " vd"}, rv32v_pkg::vreg_t'(vd_exp),
                            rv32v_pkg::vreg_t'(res_vd));
                check_value({name, " data"}, data_exp, res_data);
            end
        end
    end

    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("run did not finish within %0d cycles, %0d results outstanding",
                     timeout_cycles, exp_vd_q.size());
            $display("Checks failed");
            $fatal(1, "timeout");
        end
    end

    initial begin
        void'($urandom(38));
        rst_n       <= 1'b0;
        uop_valid   <= 1'b0;
        uop_op      <= rv32v_pkg::VALU_ADD;
        uop_src     <= rv32v_pkg::SRC_VREG;
        uop_vs1     <= '0;
        uop_vs2     <= '0;
        uop_vd      <= '0;
        uop_imm     <= '0;
        uop_scalar  <= '0;
        uop_mask_en <= 1'b0;
        res_ready   <= 1'b1;
        bp_on       <= 1'b0;
        for (int r = 0; r < rv32v_pkg::num_vregs; r++) begin
            model_regs[r] = '0;
        end
        repeat (reset_cycles) @(posedge CLK);
        rst_n <= 1'b1;
        fill_regs();
        repeat (300) issue_random("random_alu", 1'b0);
        masked_ops();
        dependency_chains();
        bp_on <= 1'b1;
        backpressure_ops();
        uop_valid <= 1'b0;
        while (exp_vd_q.size() != 0) begin
            @(posedge CLK);
        end
        // a few more cycles to catch a duplicated result
        bp_on <= 1'b0;
        repeat (20) @(posedge CLK);
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
rv32v_pkg.sv
rv32v_vector_bank.sv
rv32v_operand_stage.sv
rv32v_uop_fifo.sv
rv32v_lane_alu.sv
rv32v_ex_stage.sv
rv32v_ex_top.sv
tb_rv32v_ex_top.sv

/* Bender.yml */
package:
  name: rv32v_ex

sources:
  - rv32v_pkg.sv
  - rv32v_vector_bank.sv
  - rv32v_operand_stage.sv
  - rv32v_uop_fifo.sv
  - rv32v_lane_alu.sv
  - rv32v_ex_stage.sv
  - rv32v_ex_top.sv
  - target: test
    files:
      - tb_rv32v_ex_top.sv
